/* files.f */
+incdir+.
bus_pkg.sv
soc_map_pkg.sv
dev_bus_if.sv
bus_addr_decode.sv
scratch_ram.sv
accel_bridge.sv
bus_response_mux.sv
soc_fabric_top.sv
soc_fabric_tb.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := soc_fabric_tb
FILELIST   := files.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -j 0 --Mdir $(OBJ_DIR)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# The simulator exits non-zero on $fatal, which fails this target
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* soc_fabric_tb.sv */
// One access in flight at a time; RAM reads only touch words this run has written first
`timescale 1ns/100ps
`default_nettype none

`include "soc_params.svh"

module soc_fabric_tb;

  localparam int TIMEOUT_CYCLES = 20;

  // Access kinds as the manager model sees them
  localparam logic [1:0] K_RAM  = 2'd0;
  localparam logic [1:0] K_SYNC = 2'd1;
  localparam logic [1:0] K_APB  = 2'd2;
  localparam logic [1:0] K_NONE = 2'd3;

  logic                       clock;
  logic                       reset;
  bus_pkg::addr_t             mgr_address;
  bus_pkg::word_t             mgr_write_data;
  bus_pkg::strobe_t           mgr_write_strobe;
  logic                       mgr_read_request;
  logic                       mgr_write_request;
  bus_pkg::word_t             mgr_read_data;
  logic                       mgr_read_response;
  logic                       mgr_write_response;
  bus_pkg::addr_t             sync_address;
  bus_pkg::word_t             sync_write_data;
  logic                       sync_cs;
  logic                       sync_wr;
  bus_pkg::word_t             sync_read_data;
  logic [`SOC_APB_ADDR_W-1:0] apb_paddr;
  logic                       apb_psel;
  logic                       apb_penable;
  logic                       apb_pwrite;
  bus_pkg::word_t             apb_pwdata;
  bus_pkg::word_t             apb_prdata;
  logic                       apb_pready;
  logic                       accel_irq;
  logic                       irq_ack;
  logic                       irq_pending;

  // Manager model state
  logic [1:0]                 kind;
  logic                       in_flight;
  bus_pkg::word_t             exp_read_data;
  logic [`SOC_APB_ADDR_W-1:0] exp_paddr;
  logic                       exp_write;
  bus_pkg::word_t             exp_write_data;
  logic [1:0]                 apb_waits;
  logic [1:0]                 apb_wait_left;
  bus_pkg::word_t             ram_shadow [`SOC_RAM_WORDS];
  logic [31:0]                lfsr;
  int                         served [4];
  int                         irq_sets;
  logic                       mgr_request;
  logic                       resp_any;
  bus_pkg::apb_state_e        bridge_state;

  assign mgr_request  = mgr_read_request || mgr_write_request;
  assign resp_any     = mgr_read_response || mgr_write_response;
  assign bridge_state = i_soc_fabric_top.i_accel_bridge.apb_state;

  soc_fabric_top i_soc_fabric_top (
    .clock                (clock),
    .reset                (reset),
    .mgr_address_i        (mgr_address),
    .mgr_write_data_i     (mgr_write_data),
    .mgr_write_strobe_i   (mgr_write_strobe),
    .mgr_read_request_i   (mgr_read_request),
    .mgr_write_request_i  (mgr_write_request),
    .mgr_read_data_o      (mgr_read_data),
    .mgr_read_response_o  (mgr_read_response),
    .mgr_write_response_o (mgr_write_response),
    .sync_address_o       (sync_address),
    .sync_write_data_o    (sync_write_data),
    .sync_cs_o            (sync_cs),
    .sync_wr_o            (sync_wr),
    .sync_read_data_i     (sync_read_data),
    .apb_paddr_o          (apb_paddr),
    .apb_psel_o           (apb_psel),
    .apb_penable_o        (apb_penable),
    .apb_pwrite_o         (apb_pwrite),
    .apb_pwdata_o         (apb_pwdata),
    .apb_prdata_i         (apb_prdata),
    .apb_pready_i         (apb_pready),
    .accel_irq_i          (accel_irq),
    .irq_ack_i            (irq_ack),
    .irq_pending_o        (irq_pending)
  );

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  task automatic fail_run(input string reason);
    $display("%s", reason);
    $display("Testbench failed");
    $fatal(1);
  endtask

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] random_bits(input int count);
    logic [31:0] value;
    logic        feedback;
    value = '0;
    for (int i = 0; i < count; i++) begin
      feedback = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr     = {lfsr[30:0], feedback};
      value    = {value[30:0], feedback};
    end
    return value;
  endfunction

  // ----------------------------------------
  // Target models
  // ----------------------------------------
  always @(posedge clock or posedge reset) begin
    if (reset) begin
      sync_read_data <= '0;
    end else if (sync_cs && !sync_wr) begin
      sync_read_data <= sync_address ^ 32'hA5A5_0000;
    end
  end

  // Wait count is picked by the manager when it issues the APB access
  always @(posedge clock or posedge reset) begin
    if (reset) begin
      apb_pready    <= 1'b0;
      apb_prdata    <= '0;
      apb_wait_left <= '0;
    end else if (apb_psel && !apb_penable) begin
      apb_pready    <= (apb_waits == 2'd0);
      apb_prdata    <= 32'(apb_paddr) ^ 32'h0000_5A5A;
      apb_wait_left <= apb_waits;
    end else if (apb_penable && !apb_pready) begin
      apb_pready    <= (apb_wait_left == 2'd1);
      apb_wait_left <= apb_wait_left - 2'd1;
    end else begin
      apb_pready <= 1'b0;
    end
  end

  // ----------------------------------------
  // Checks
  // ----------------------------------------
  assert property (@(posedge clock) reset |->
    !(resp_any || sync_cs || apb_psel || apb_penable || irq_pending))
    else fail_run("response, select or interrupt output active during reset");

  assert property (@(posedge clock) $fell(reset) |->
    !(resp_any || sync_cs || apb_psel || apb_penable || irq_pending) &&
    bridge_state == bus_pkg::APB_IDLE)
    else fail_run($sformatf("outputs active or bridge in %s right after reset",
                            bridge_state.name()));

  assert property (@(posedge clock) disable iff (reset) mgr_request && kind != K_APB |=>
    mgr_read_response == $past(mgr_read_request) && mgr_write_response == $past(mgr_write_request))
    else fail_run("response did not come exactly one cycle after the request");

  assert property (@(posedge clock) disable iff (reset) resp_any |-> in_flight)
    else fail_run("response without an access in flight");

  assert property (@(posedge clock) disable iff (reset) mgr_read_response |->
    mgr_read_data == exp_read_data)
    else fail_run($sformatf("MISMATCH mgr_read_data_o got 0x%h expected 0x%h",
                            $sampled(mgr_read_data), $sampled(exp_read_data)));

  // Fixed-latency port
  assert property (@(posedge clock) disable iff (reset) sync_cs == (mgr_request && kind == K_SYNC))
    else fail_run($sformatf("MISMATCH sync_cs_o got 0x%h expected 0x%h", $sampled(sync_cs),
                            $sampled(mgr_request && kind == K_SYNC)));

  assert property (@(posedge clock) disable iff (reset) sync_cs |-> sync_wr == mgr_write_request)
    else fail_run($sformatf("MISMATCH sync_wr_o got 0x%h expected 0x%h",
                            $sampled(sync_wr), $sampled(mgr_write_request)));

  assert property (@(posedge clock) disable iff (reset) sync_cs |-> sync_address == mgr_address)
    else fail_run($sformatf("MISMATCH sync_address_o got 0x%h expected 0x%h",
                            $sampled(sync_address), $sampled(mgr_address)));

  assert property (@(posedge clock) disable iff (reset) sync_cs && sync_wr |->
    sync_write_data == mgr_write_data)
    else fail_run($sformatf("MISMATCH sync_write_data_o got 0x%h expected 0x%h",
                            $sampled(sync_write_data), $sampled(mgr_write_data)));

  // APB sequencing
  assert property (@(posedge clock) disable iff (reset) mgr_request && kind == K_APB |=>
    apb_psel && !apb_penable)
    else fail_run("psel not raised alone in the cycle after the APB request");

  assert property (@(posedge clock) disable iff (reset) apb_psel && !apb_penable |=>
    apb_psel && apb_penable)
    else fail_run("penable did not follow the SETUP cycle");

  assert property (@(posedge clock) disable iff (reset) $rose(apb_psel) |->
    $past(mgr_request && kind == K_APB))
    else fail_run("psel raised without an APB request");

  assert property (@(posedge clock) disable iff (reset) apb_psel |-> apb_paddr == exp_paddr)
    else fail_run($sformatf("MISMATCH apb_paddr_o got 0x%h expected 0x%h",
                            $sampled(apb_paddr), $sampled(exp_paddr)));

  assert property (@(posedge clock) disable iff (reset) apb_psel |-> apb_pwrite == exp_write)
    else fail_run($sformatf("MISMATCH apb_pwrite_o got 0x%h expected 0x%h",
                            $sampled(apb_pwrite), $sampled(exp_write)));

  assert property (@(posedge clock) disable iff (reset) apb_psel && exp_write |->
    apb_pwdata == exp_write_data)
    else fail_run($sformatf("MISMATCH apb_pwdata_o got 0x%h expected 0x%h",
                            $sampled(apb_pwdata), $sampled(exp_write_data)));

  assert property (@(posedge clock) disable iff (reset) apb_penable && !apb_pready |=>
    $stable(apb_paddr))
    else fail_run("paddr moved during a wait state");

  assert property (@(posedge clock) disable iff (reset) apb_penable && apb_pready |->
    mgr_read_response == !apb_pwrite && mgr_write_response == apb_pwrite)
    else fail_run("no manager response in the pready cycle");

  assert property (@(posedge clock) disable iff (reset) resp_any && kind == K_APB |->
    apb_penable && apb_pready)
    else fail_run("APB response outside the pready cycle");

  // Interrupt pending latch
  assert property (@(posedge clock) disable iff (reset) $rose(accel_irq) |=> irq_pending)
    else fail_run("irq_pending_o not set after a rising edge");

  assert property (@(posedge clock) disable iff (reset) irq_pending && !irq_ack |=> irq_pending)
    else fail_run("irq_pending_o dropped without an acknowledge");

  assert property (@(posedge clock) disable iff (reset) irq_ack && !$rose(accel_irq) |=>
    !irq_pending)
    else fail_run("irq_pending_o not cleared by the acknowledge");

  assert property (@(posedge clock) disable iff (reset) !irq_pending && !$rose(accel_irq) |=>
    !irq_pending)
    else fail_run("irq_pending_o set without a new edge");

  // ----------------------------------------
  // Manager model
  // ----------------------------------------
  task automatic await_response(input logic [1:0] access_kind);
    int cycles;
    for (cycles = 0; cycles < TIMEOUT_CYCLES; cycles++) begin
      @(negedge clock);
      if (resp_any) begin
        break;
      end
    end
    if (cycles == TIMEOUT_CYCLES) begin
      fail_run("no response from the fabric within the timeout");
    end else begin
      served[access_kind]++;
      @(posedge clock);
      in_flight <= 1'b0;
    end
  endtask

  task automatic issue(input logic is_write, input bus_pkg::addr_t address,
                       input bus_pkg::word_t data, input bus_pkg::strobe_t strobe,
                       input logic [1:0] access_kind, input bus_pkg::word_t expected);
    logic [31:0] waits_pick;
    waits_pick = (access_kind == K_APB) ? random_bits(2) : '0;
    @(posedge clock);
    mgr_address       <= address;
    mgr_write_data    <= data;
    mgr_write_strobe  <= strobe;
    mgr_read_request  <= !is_write;
    mgr_write_request <= is_write;
    kind              <= access_kind;
    exp_read_data     <= expected;
    exp_paddr         <= address[`SOC_APB_ADDR_W-1:0];
    exp_write         <= is_write;
    exp_write_data    <= data;
    apb_waits         <= waits_pick[1:0];
    in_flight         <= 1'b1;
    @(posedge clock);
    mgr_read_request  <= 1'b0;
    mgr_write_request <= 1'b0;
    await_response(access_kind);
  endtask

  task automatic await_pending();
    int cycles;
    for (cycles = 0; cycles < TIMEOUT_CYCLES; cycles++) begin
      @(negedge clock);
      if (irq_pending) begin
        break;
      end
    end
    if (cycles == TIMEOUT_CYCLES) begin
      fail_run("irq_pending_o never set after an interrupt edge");
    end else begin
      irq_sets++;
    end
  endtask

  initial begin
    bus_pkg::addr_t   address;
    bus_pkg::word_t   data;
    bus_pkg::strobe_t strobe;
    logic [7:0]       index;
    reset             = 1'b1;
    mgr_address       = '0;
    mgr_write_data    = '0;
    mgr_write_strobe  = '0;
    mgr_read_request  = 1'b0;
    mgr_write_request = 1'b0;
    accel_irq         = 1'b0;
    irq_ack           = 1'b0;
    kind              = K_NONE;
    in_flight         = 1'b0;
    exp_read_data     = '0;
    exp_paddr         = '0;
    exp_write         = 1'b0;
    exp_write_data    = '0;
    apb_waits         = '0;
    lfsr              = 32'h5264_3de8;
    irq_sets          = 0;
    for (int k = 0; k < 4; k++) begin
      served[k] = 0;
    end
    repeat (5) @(posedge clock);
    reset <= 1'b0;
    repeat (2) @(posedge clock);

    // Full word, then a strobed merge, then read back
    for (int n = 0; n < 8; n++) begin
      index   = 8'(random_bits(8));
      address = `SOC_RAM_BASE + {22'h0, index, 2'b00};
      data    = random_bits(32);
      issue(1'b1, address, data, 4'hF, K_RAM, '0);
      ram_shadow[index] = data;
      data   = random_bits(32);
      strobe = 4'(random_bits(4));
      issue(1'b1, address, data, strobe, K_RAM, '0);
      for (int b = 0; b < 4; b++) begin
        if (strobe[b]) begin
          ram_shadow[index][8*b +: 8] = data[8*b +: 8];
        end
      end
      issue(1'b0, address, '0, '0, K_RAM, ram_shadow[index]);
    end

    for (int n = 0; n < 6; n++) begin
      address = `SOC_SYNC_BASE + {16'h0, 16'(random_bits(16)) & 16'hFFFC};
      issue(n[0], address, random_bits(32), 4'hF, K_SYNC, address ^ 32'hA5A5_0000);
    end

    for (int n = 0; n < 8; n++) begin
      address = `SOC_APB_BASE + {20'h0, 12'(random_bits(12)) & 12'hFFC};
      data    = {20'h0, address[`SOC_APB_ADDR_W-1:0]} ^ 32'h0000_5A5A;
      issue(n % 4 == 3, address, random_bits(32), 4'hF, K_APB, data);
    end

    // Outside every region, including the words just past RAM and before the sync port
    issue(1'b0, 32'h4000_0000, '0, '0, K_NONE, '0);
    issue(1'b1, 32'h8006_0000, 32'h1234_5678, 4'hF, K_NONE, '0);
    issue(1'b0, `SOC_RAM_BASE + `SOC_RAM_SIZE, '0, '0, K_NONE, '0);
    issue(1'b0, `SOC_SYNC_BASE - 32'd4, '0, '0, K_NONE, '0);

    // Interrupt edge, hold, acknowledge while high, then edge together with acknowledge
    @(posedge clock);
    accel_irq <= 1'b1;
    await_pending();
    repeat (4) @(posedge clock);
    irq_ack <= 1'b1;
    @(posedge clock);
    irq_ack <= 1'b0;
    repeat (4) @(posedge clock);
    accel_irq <= 1'b0;
    @(posedge clock);
    accel_irq <= 1'b1;
    irq_ack   <= 1'b1;
    @(posedge clock);
    irq_ack <= 1'b0;
    await_pending();
    @(posedge clock);
    irq_ack <= 1'b1;
    @(posedge clock);
    irq_ack   <= 1'b0;
    accel_irq <= 1'b0;
    repeat (3) @(posedge clock);

    if (served[K_RAM] > 0 && served[K_SYNC] > 0 && served[K_APB] > 0 &&
        served[K_NONE] > 0 && irq_sets == 2) begin
      $display("Testbench passed");
      $finish;
    end else begin
      fail_run("stimulus did not reach every access kind and interrupt case");
    end
  end

endmodule

`default_nettype wire

/* soc_fabric_top.sv */
// Single manager, one access in flight; latency is that of the addressed target
`timescale 1ns/100ps
`default_nettype none

`include "soc_params.svh"

module soc_fabric_top (
  input  logic                       clock,
  input  logic                       reset,
  // Manager
  input  bus_pkg::addr_t             mgr_address_i,
  input  bus_pkg::word_t             mgr_write_data_i,
  input  bus_pkg::strobe_t           mgr_write_strobe_i,
  input  logic                       mgr_read_request_i,
  input  logic                       mgr_write_request_i,
  output bus_pkg::word_t             mgr_read_data_o,
  output logic                       mgr_read_response_o,
  output logic                       mgr_write_response_o,
  // Fixed-latency accelerator
  output bus_pkg::addr_t             sync_address_o,
  output bus_pkg::word_t             sync_write_data_o,
  output logic                       sync_cs_o,
  output logic                       sync_wr_o,
  input  bus_pkg::word_t             sync_read_data_i,
  // APB accelerator
  output logic [`SOC_APB_ADDR_W-1:0] apb_paddr_o,
  output logic                       apb_psel_o,
  output logic                       apb_penable_o,
  output logic                       apb_pwrite_o,
  output bus_pkg::word_t             apb_pwdata_o,
  input  bus_pkg::word_t             apb_prdata_i,
  input  logic                       apb_pready_i,
  // Interrupt
  input  logic                       accel_irq_i,
  input  logic                       irq_ack_i,
  output logic                       irq_pending_o
);

  soc_map_pkg::target_e served_target;
  logic                 busy;

  dev_bus_if ram_bus ();
  dev_bus_if sync_bus ();
  dev_bus_if apb_bus ();

  bus_addr_decode i_bus_addr_decode (
    .clock               (clock),
    .reset               (reset),
    .mgr_address_i       (mgr_address_i),
    .mgr_write_data_i    (mgr_write_data_i),
    .mgr_write_strobe_i  (mgr_write_strobe_i),
    .mgr_read_request_i  (mgr_read_request_i),
    .mgr_write_request_i (mgr_write_request_i),
    .ram_bus             (ram_bus),
    .sync_bus            (sync_bus),
    .apb_bus             (apb_bus),
    .served_target_o     (served_target),
    .busy_i              (busy)
  );

  scratch_ram i_scratch_ram (
    .clock (clock),
    .reset (reset),
    .bus   (ram_bus)
  );

  accel_bridge i_accel_bridge (
    .clock             (clock),
    .reset             (reset),
    .sync_bus          (sync_bus),
    .apb_bus           (apb_bus),
    .sync_address_o    (sync_address_o),
    .sync_write_data_o (sync_write_data_o),
    .sync_cs_o         (sync_cs_o),
    .sync_wr_o         (sync_wr_o),
    .sync_read_data_i  (sync_read_data_i),
    .apb_paddr_o       (apb_paddr_o),
    .apb_psel_o        (apb_psel_o),
    .apb_penable_o     (apb_penable_o),
    .apb_pwrite_o      (apb_pwrite_o),
    .apb_pwdata_o      (apb_pwdata_o),
    .apb_prdata_i      (apb_prdata_i),
    .apb_pready_i      (apb_pready_i),
    .accel_irq_i       (accel_irq_i),
    .irq_ack_i         (irq_ack_i),
    .irq_pending_o     (irq_pending_o)
  );

  bus_response_mux i_bus_response_mux (
    .clock                (clock),
    .reset                (reset),
    .ram_bus              (ram_bus),
    .sync_bus             (sync_bus),
    .apb_bus              (apb_bus),
    .served_target_i      (served_target),
    .mgr_read_request_i   (mgr_read_request_i),
    .mgr_write_request_i  (mgr_write_request_i),
    .mgr_read_data_o      (mgr_read_data_o),
    .mgr_read_response_o  (mgr_read_response_o),
    .mgr_write_response_o (mgr_write_response_o),
    .busy_o               (busy)
  );

endmodule

`default_nettype wire

/* bus_response_mux.sv */
// Follows the target registered by the decoder; unmapped accesses answer one cycle later with zero
`timescale 1ns/100ps
`default_nettype none

module bus_response_mux (
  input  logic                 clock,
  input  logic                 reset,
  dev_bus_if.result            ram_bus,
  dev_bus_if.result            sync_bus,
  dev_bus_if.result            apb_bus,
  input  soc_map_pkg::target_e served_target_i,
  input  logic                 mgr_read_request_i,
  input  logic                 mgr_write_request_i,
  output bus_pkg::word_t       mgr_read_data_o,
  output logic                 mgr_read_response_o,
  output logic                 mgr_write_response_o,
  output logic                 busy_o
);

  logic read_request_q;
  logic write_request_q;

  // Last-cycle requests, used only when nothing was hit
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      read_request_q  <= 1'b0;
      write_request_q <= 1'b0;
      busy_o          <= 1'b0;
    end else begin
      read_request_q  <= mgr_read_request_i;
      write_request_q <= mgr_write_request_i;
      if (mgr_read_request_i || mgr_write_request_i) begin
        busy_o <= 1'b1;
      end else if (mgr_read_response_o || mgr_write_response_o) begin
        busy_o <= 1'b0;
      end
    end
  end

  always_comb begin
    case (served_target_i)
      soc_map_pkg::TGT_RAM: begin
        mgr_read_data_o      = ram_bus.read_data;
        mgr_read_response_o  = ram_bus.read_response;
        mgr_write_response_o = ram_bus.write_response;
      end
      soc_map_pkg::TGT_SYNC: begin
        mgr_read_data_o      = sync_bus.read_data;
        mgr_read_response_o  = sync_bus.read_response;
        mgr_write_response_o = sync_bus.write_response;
      end
      soc_map_pkg::TGT_APB: begin
        mgr_read_data_o      = apb_bus.read_data;
        mgr_read_response_o  = apb_bus.read_response;
        mgr_write_response_o = apb_bus.write_response;
      end
      default: begin
        mgr_read_data_o      = '0;
        mgr_read_response_o  = read_request_q;
        mgr_write_response_o = write_request_q;
      end
    endcase
  end

endmodule

`default_nettype wire

/* accel_bridge.sv */
// Accelerator ports; sync target answers in one cycle, APB target may stretch ACCESS with pready
`timescale 1ns/100ps
`default_nettype none

`include "soc_params.svh"

module accel_bridge (
  input  logic                       clock,
  input  logic                       reset,
  dev_bus_if.target                  sync_bus,
  dev_bus_if.target                  apb_bus,
  output bus_pkg::addr_t             sync_address_o,
  output bus_pkg::word_t             sync_write_data_o,
  output logic                       sync_cs_o,
  output logic                       sync_wr_o,
  input  bus_pkg::word_t             sync_read_data_i,
  output logic [`SOC_APB_ADDR_W-1:0] apb_paddr_o,
  output logic                       apb_psel_o,
  output logic                       apb_penable_o,
  output logic                       apb_pwrite_o,
  output bus_pkg::word_t             apb_pwdata_o,
  input  bus_pkg::word_t             apb_prdata_i,
  input  logic                       apb_pready_i,
  input  logic                       accel_irq_i,
  input  logic                       irq_ack_i,
  output logic                       irq_pending_o
);

  // ----------------------------------------
  // Fixed-latency port
  // ----------------------------------------
  logic sync_read_response_q;
  logic sync_write_response_q;

  assign sync_cs_o         = sync_bus.read_request || sync_bus.write_request;
  assign sync_wr_o         = sync_bus.write_request;
  assign sync_address_o    = sync_bus.address;
  assign sync_write_data_o = sync_bus.write_data;

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      sync_read_response_q  <= 1'b0;
      sync_write_response_q <= 1'b0;
    end else begin
      sync_read_response_q  <= sync_bus.read_request;
      sync_write_response_q <= sync_bus.write_request;
    end
  end

  // Engine output is valid in the response cycle
  assign sync_bus.read_data      = sync_read_data_i;
  assign sync_bus.read_response  = sync_read_response_q;
  assign sync_bus.write_response = sync_write_response_q;

  // ----------------------------------------
  // APB bridge
  // ----------------------------------------
  bus_pkg::apb_state_e         apb_state;
  logic [`SOC_APB_ADDR_W-1:0]  paddr_q;
  bus_pkg::word_t              pwdata_q;
  logic                        pwrite_q;
  logic                        apb_request;
  logic                        apb_done;

  assign apb_request = apb_bus.read_request || apb_bus.write_request;
  assign apb_done    = (apb_state == bus_pkg::APB_ACCESS) && apb_pready_i;

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      apb_state <= bus_pkg::APB_IDLE;
    end else begin
      case (apb_state)
        bus_pkg::APB_IDLE: begin
          if (apb_request) begin
            apb_state <= bus_pkg::APB_SETUP;
          end
        end
        bus_pkg::APB_SETUP:  apb_state <= bus_pkg::APB_ACCESS;
        bus_pkg::APB_ACCESS: begin
          if (apb_pready_i) begin
            apb_state <= bus_pkg::APB_IDLE;
          end
        end
        default: apb_state <= bus_pkg::APB_IDLE;
      endcase
    end
  end

  // Request fields held for the whole transfer
  always_ff @(posedge clock) begin
    if (apb_request) begin
      paddr_q  <= apb_bus.address[`SOC_APB_ADDR_W-1:0];
      pwdata_q <= apb_bus.write_data;
      pwrite_q <= apb_bus.write_request;
    end
  end

  assign apb_paddr_o   = paddr_q;
  assign apb_pwdata_o  = pwdata_q;
  assign apb_pwrite_o  = pwrite_q;
  assign apb_psel_o    = (apb_state == bus_pkg::APB_SETUP) || (apb_state == bus_pkg::APB_ACCESS);
  assign apb_penable_o = (apb_state == bus_pkg::APB_ACCESS);

  assign apb_bus.read_data      = apb_prdata_i;
  assign apb_bus.read_response  = apb_done && !pwrite_q;
  assign apb_bus.write_response = apb_done && pwrite_q;

  // ----------------------------------------
  // Interrupt edge capture
  // ----------------------------------------
  logic irq_q;

  // A new edge takes priority over the acknowledge
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      irq_q         <= 1'b0;
      irq_pending_o <= 1'b0;
    end else begin
      irq_q <= accel_irq_i;
      if (accel_irq_i && !irq_q) begin
        irq_pending_o <= 1'b1;
      end else if (irq_ack_i) begin
        irq_pending_o <= 1'b0;
      end
    end
  end

  // Address must not move between SETUP and the end of ACCESS
  assert property (@(posedge clock) disable iff (reset) apb_penable_o |-> $stable(apb_paddr_o))
    else $error("paddr changed during an APB transfer");

endmodule

`default_nettype wire

/* scratch_ram.sv */
// Word-addressed RAM with no init contents; byte offset bits are ignored
`timescale 1ns/100ps
`default_nettype none

`include "soc_params.svh"

module scratch_ram (
  input  logic      clock,
  input  logic      reset,
  dev_bus_if.target bus
);

  localparam int IDX_W = $clog2(`SOC_RAM_WORDS);

  bus_pkg::word_t   mem [`SOC_RAM_WORDS];
  bus_pkg::word_t   read_data_q;
  logic [IDX_W-1:0] word_index;
  logic             read_response_q;
  logic             write_response_q;

  assign word_index = bus.address[IDX_W+1:2];

  // Byte merge under the strobe
  always_ff @(posedge clock) begin
    if (bus.write_request) begin
      for (int b = 0; b < `SOC_STRB_W; b++) begin
        if (bus.write_strobe[b]) begin
          mem[word_index][8*b +: 8] <= bus.write_data[8*b +: 8];
        end
      end
    end
    if (bus.read_request) begin
      read_data_q <= mem[word_index];
    end
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      read_response_q  <= 1'b0;
      write_response_q <= 1'b0;
    end else begin
      read_response_q  <= bus.read_request;
      write_response_q <= bus.write_request;
    end
  end

  assign bus.read_data      = read_data_q;
  assign bus.read_response  = read_response_q;
  assign bus.write_response = write_response_q;

  // Decoder must never route an address beyond the RAM depth
  assert property (@(posedge clock) disable iff (reset)
    (bus.read_request || bus.write_request) |-> (bus.address >> 2) < `SOC_RAM_WORDS)
    else $error("RAM access beyond the last word");

endmodule

`default_nettype wire

/* bus_addr_decode.sv */
// Expects at most one access in flight; unmapped requests are dropped here and answered by the mux
`timescale 1ns/100ps
`default_nettype none

module bus_addr_decode (
  input  logic                clock,
  input  logic                reset,
  input  bus_pkg::addr_t      mgr_address_i,
  input  bus_pkg::word_t      mgr_write_data_i,
  input  bus_pkg::strobe_t    mgr_write_strobe_i,
  input  logic                mgr_read_request_i,
  input  logic                mgr_write_request_i,
  dev_bus_if.decoder          ram_bus,
  dev_bus_if.decoder          sync_bus,
  dev_bus_if.decoder          apb_bus,
  output soc_map_pkg::target_e served_target_o,
  input  logic                busy_i
);

  soc_map_pkg::target_e hit_target;
  logic                 any_request;

  assign any_request = mgr_read_request_i || mgr_write_request_i;

  always_comb begin
    if (soc_map_pkg::in_region(mgr_address_i, soc_map_pkg::RAM_REGION)) begin
      hit_target = soc_map_pkg::TGT_RAM;
    end else if (soc_map_pkg::in_region(mgr_address_i, soc_map_pkg::SYNC_REGION)) begin
      hit_target = soc_map_pkg::TGT_SYNC;
    end else if (soc_map_pkg::in_region(mgr_address_i, soc_map_pkg::APB_REGION)) begin
      hit_target = soc_map_pkg::TGT_APB;
    end else begin
      hit_target = soc_map_pkg::TGT_NONE;
    end
  end

  // Payload goes to every target, only the matched one sees a request
  assign ram_bus.address       = mgr_address_i;
  assign ram_bus.write_data    = mgr_write_data_i;
  assign ram_bus.write_strobe  = mgr_write_strobe_i;
  assign ram_bus.read_request  = mgr_read_request_i && (hit_target == soc_map_pkg::TGT_RAM);
  assign ram_bus.write_request = mgr_write_request_i && (hit_target == soc_map_pkg::TGT_RAM);

  assign sync_bus.address       = mgr_address_i;
  assign sync_bus.write_data    = mgr_write_data_i;
  assign sync_bus.write_strobe  = mgr_write_strobe_i;
  assign sync_bus.read_request  = mgr_read_request_i && (hit_target == soc_map_pkg::TGT_SYNC);
  assign sync_bus.write_request = mgr_write_request_i && (hit_target == soc_map_pkg::TGT_SYNC);

  assign apb_bus.address       = mgr_address_i;
  assign apb_bus.write_data    = mgr_write_data_i;
  assign apb_bus.write_strobe  = mgr_write_strobe_i;
  assign apb_bus.read_request  = mgr_read_request_i && (hit_target == soc_map_pkg::TGT_APB);
  assign apb_bus.write_request = mgr_write_request_i && (hit_target == soc_map_pkg::TGT_APB);

  // Held until the next request so the mux follows the slow APB target too
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      served_target_o <= soc_map_pkg::TGT_NONE;
    end else if (any_request) begin
      served_target_o <= hit_target;
    end
  end

  // ----------------------------------------
  // Manager protocol checks
  // ----------------------------------------
  assert property (@(posedge clock) disable iff (reset) any_request |-> !busy_i)
    else $error("new request while an access is still in flight");

  assert property (@(posedge clock) disable iff (reset)
    !(mgr_read_request_i && mgr_write_request_i))
    else $error("read and write requested in the same cycle");

endmodule

`default_nettype wire

/* dev_bus_if.sv */
// One target link; requests are single-cycle pulses and responses are single-cycle pulses
`timescale 1ns/100ps
`default_nettype none

interface dev_bus_if;

  // Request side, from the decoder
  bus_pkg::addr_t   address;
  bus_pkg::word_t   write_data;
  bus_pkg::strobe_t write_strobe;
  logic             read_request;
  logic             write_request;

  // Response side, from the target
  bus_pkg::word_t   read_data;
  logic             read_response;
  logic             write_response;

  modport decoder (
    output address, write_data, write_strobe, read_request, write_request
  );

  modport target (
    input  address, write_data, write_strobe, read_request, write_request,
    output read_data, read_response, write_response
  );

  modport result (
    input read_data, read_response, write_response
  );

endinterface

`default_nettype wire

/* soc_map_pkg.sv */
// Address map types; a region matches when the offset from its base is below its size
`default_nettype none

`include "soc_params.svh"

package soc_map_pkg;

  // Targets reachable from the manager
  typedef enum logic [1:0] {
    TGT_RAM  = 2'd0,
    TGT_SYNC = 2'd1,
    TGT_APB  = 2'd2,
    TGT_NONE = 2'd3
  } target_e;

  typedef struct packed {
    logic [`SOC_ADDR_W-1:0] base;
    logic [`SOC_ADDR_W-1:0] size;
  } region_t;

  localparam region_t RAM_REGION  = '{base: `SOC_RAM_BASE,  size: `SOC_RAM_SIZE};
  localparam region_t SYNC_REGION = '{base: `SOC_SYNC_BASE, size: `SOC_SYNC_SIZE};
  localparam region_t APB_REGION  = '{base: `SOC_APB_BASE,  size: `SOC_APB_SIZE};

  // Unsigned wrap makes addresses below the base fail the compare
  function automatic logic in_region(logic [`SOC_ADDR_W-1:0] addr, region_t region);
    return (addr - region.base) < region.size;
  endfunction

endpackage

`default_nettype wire

/* bus_pkg.sv */
// Bus payload types; one word size for every target, APB state encoding shared with the testbench
`default_nettype none

`include "soc_params.svh"

package bus_pkg;

  typedef logic [`SOC_DATA_W-1:0] word_t;
  typedef logic [`SOC_ADDR_W-1:0] addr_t;
  typedef logic [`SOC_STRB_W-1:0] strobe_t;

  // APB bridge sequencing
  typedef enum logic [1:0] {
    APB_IDLE,
    APB_SETUP,
    APB_ACCESS
  } apb_state_e;

endpackage

`default_nettype wire

/* soc_params.svh */
// Fixed map and widths; region sizes must be powers of two and regions must not overlap
`ifndef SOC_PARAMS_SVH
`define SOC_PARAMS_SVH

// Bus widths
`define SOC_ADDR_W      32
`define SOC_DATA_W      32
`define SOC_STRB_W      4

// Scratch RAM depth in words
`define SOC_RAM_WORDS   256

// ----------------------------------------
// Address map
// ----------------------------------------
`define SOC_RAM_BASE    32'h0000_0000
`define SOC_RAM_SIZE    32'h0000_0400

`define SOC_SYNC_BASE   32'h8004_0000
`define SOC_SYNC_SIZE   32'h0001_0000

`define SOC_APB_BASE    32'h8005_0000
`define SOC_APB_SIZE    32'h0001_0000

// APB accelerator register space
`define SOC_APB_ADDR_W  12

`endif
